// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

	localparam int XLEN       = 32;
	localparam int ILEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 1 << REG_ADDR_W;
	localparam int SHAMT_W    = $clog2(XLEN);

	// ----------------------------------------
	// major opcodes in inst[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	// func_3 of OP and OP-IMM
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000,	// add, sub, addi
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101,	// srl or sra, picked by inst[30]
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} alu_f3_e;

	// func_3 of the conditional branches, 010 and 011 are reserved
	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} branch_f3_e;

	// ----------------------------------------
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

endpackage

// ==== source/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

	import rv_isa_pkg::*;

	// ----------------------------------------
	// decode to execute
	typedef struct packed {
		logic                  valid;
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd_num;
		alu_op_e               alu_op;
		logic [XLEN-1:0]       op_a;
		logic [XLEN-1:0]       op_b;
		logic                  writes_rd;
		logic                  link;	// result is pc+4
		logic                  illegal;
	} dec_rec_t;

	// execute to result
	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd_num;
		logic                  writes_rd;
		logic [XLEN-1:0]       result;
		logic                  illegal;
	} exe_rec_t;

	// register file write, also the writeback output
	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd_num;
		logic [XLEN-1:0]       value;
	} wb_rec_t;

	typedef struct packed {
		logic            valid;
		logic            taken;
		logic [XLEN-1:0] target;
	} br_rec_t;

endpackage

// ==== source/register_file.sv ====
module register_file import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic [REG_ADDR_W-1:0] i_rs1_num,
	input  logic [REG_ADDR_W-1:0] i_rs2_num,
	input  wb_rec_t               i_wb,
	output logic [XLEN-1:0]       o_rs1,
	output logic [XLEN-1:0]       o_rs2
);

	// x0 has no storage
	logic [XLEN-1:0] regs [NUM_REGS-1:1];

	// ----------------------------------------
	// write port
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.valid && (i_wb.rd_num != '0)) begin
			regs[i_wb.rd_num] <= i_wb.value;
		end
	end

	// ----------------------------------------
	// read ports, no write-through
	always_comb begin
		if (i_rs1_num == '0) begin
			o_rs1 = '0;
		end else begin
			o_rs1 = regs[i_rs1_num];
		end
	end

	always_comb begin
		if (i_rs2_num == '0) begin
			o_rs2 = '0;
		end else begin
			o_rs2 = regs[i_rs2_num];
		end
	end

endmodule

// ==== source/branch_unit.sv ====
module branch_unit import rv_isa_pkg::*;
(
	input  logic [XLEN-1:0] i_pc,
	input  opcode_e         i_opcode,
	input  logic [2:0]      i_func_3,
	input  logic [XLEN-1:0] i_imm_i,
	input  logic [XLEN-1:0] i_imm_b,
	input  logic [XLEN-1:0] i_imm_j,
	input  logic [XLEN-1:0] i_rs1,
	input  logic [XLEN-1:0] i_rs2,
	output logic            o_taken,
	output logic [XLEN-1:0] o_target
);

	logic            cond;
	logic [XLEN-1:0] jalr_sum;

	assign jalr_sum = i_rs1 + i_imm_i;

	// ----------------------------------------
	// branch condition
	always_comb begin
		case (branch_f3_e'(i_func_3))
			F3_BEQ:  cond = (i_rs1 == i_rs2);
			F3_BNE:  cond = (i_rs1 != i_rs2);
			F3_BLT:  cond = ($signed(i_rs1) < $signed(i_rs2));
			F3_BGE:  cond = ($signed(i_rs1) >= $signed(i_rs2));
			F3_BLTU: cond = (i_rs1 < i_rs2);
			F3_BGEU: cond = (i_rs1 >= i_rs2);
			default: cond = 1'b0;	// reserved encodings
		endcase
	end

	// ----------------------------------------
	// taken flag and target
	always_comb begin
		case (i_opcode)
			OPC_BRANCH: begin
				o_taken  = cond;
				o_target = i_pc + i_imm_b;
			end
			OPC_JAL: begin
				o_taken  = 1'b1;
				o_target = i_pc + i_imm_j;
			end
			OPC_JALR: begin
				o_taken  = 1'b1;
				o_target = {jalr_sum[XLEN-1:1], 1'b0};	// bit 0 cleared
			end
			default: begin
				o_taken  = 1'b0;
				o_target = i_pc + i_imm_b;
			end
		endcase
	end

endmodule

// ==== source/decode_stage.sv ====
module decode_stage import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_inst_valid,
	input  logic [ILEN-1:0] i_inst,
	input  logic [XLEN-1:0] i_pc,
	input  wb_rec_t         i_wb,
	output dec_rec_t        o_dec,
	output br_rec_t         o_br
);

	opcode_e               opcode;
	logic [2:0]            func_3;
	logic [REG_ADDR_W-1:0] rs1_num, rs2_num, rd_num;
	logic [XLEN-1:0]       imm_i, imm_b, imm_j, imm_u;
	logic [XLEN-1:0]       rs1, rs2;
	logic                  is_ctl;	// branch, jal or jalr
	logic                  taken;
	logic [XLEN-1:0]       target;
	dec_rec_t              dec_d;
	br_rec_t               br_d;

	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
	                                       input logic is_reg);
		case (alu_f3_e'(f3))
			F3_ADD:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;	// no subi
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return alt ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			F3_AND:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	// ----------------------------------------
	// fields and immediates
	assign opcode  = opcode_e'(i_inst[6:0]);
	assign func_3  = i_inst[14:12];
	assign rd_num  = i_inst[11:7];
	assign rs1_num = i_inst[19:15];
	assign rs2_num = i_inst[24:20];
	assign imm_i   = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_b   = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_j   = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
	assign imm_u   = {i_inst[31:12], 12'b0};

	register_file u_regs (.i_clk(i_clk), .i_rst(i_rst), .i_rs1_num(rs1_num),
		.i_rs2_num(rs2_num), .i_wb(i_wb), .o_rs1(rs1), .o_rs2(rs2));

	branch_unit u_branch (.i_pc(i_pc), .i_opcode(opcode), .i_func_3(func_3),
		.i_imm_i(imm_i), .i_imm_b(imm_b), .i_imm_j(imm_j), .i_rs1(rs1), .i_rs2(rs2),
		.o_taken(taken), .o_target(target));

	// ----------------------------------------
	// control and operand select
	always_comb begin
		dec_d        = '0;
		dec_d.valid  = i_inst_valid;
		dec_d.pc     = i_pc;
		dec_d.rd_num = rd_num;
		dec_d.alu_op = ALU_ADD;
		dec_d.op_a   = rs1;
		dec_d.op_b   = rs2;
		is_ctl       = 1'b0;
		case (opcode)
			OPC_OP: begin
				dec_d.alu_op    = alu_decode(func_3, i_inst[30], 1'b1);
				dec_d.writes_rd = 1'b1;
			end
			OPC_OP_IMM: begin
				dec_d.alu_op    = alu_decode(func_3, i_inst[30], 1'b0);
				dec_d.op_b      = imm_i;
				dec_d.writes_rd = 1'b1;
			end
			OPC_LUI: begin
				dec_d.alu_op    = ALU_PASS_B;
				dec_d.op_a      = '0;
				dec_d.op_b      = imm_u;
				dec_d.writes_rd = 1'b1;
			end
			OPC_AUIPC: begin
				dec_d.op_a      = i_pc;
				dec_d.op_b      = imm_u;
				dec_d.writes_rd = 1'b1;
			end
			OPC_JAL, OPC_JALR: begin
				dec_d.writes_rd = 1'b1;
				dec_d.link      = 1'b1;
				is_ctl          = 1'b1;
			end
			OPC_BRANCH: begin
				is_ctl        = 1'b1;
				dec_d.illegal = (func_3[2:1] == 2'b01);	// reserved func_3
			end
			default: dec_d.illegal = 1'b1;
		endcase
	end

	assign br_d.valid  = i_inst_valid && is_ctl && !dec_d.illegal;
	assign br_d.taken  = taken;
	assign br_d.target = target;

	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		o_dec <= dec_d;
		o_br  <= br_d;
		if (i_rst) begin
			o_dec.valid <= 1'b0;
			o_br.valid  <= 1'b0;
		end
	end

endmodule

// ==== source/execute_stage.sv ====
module execute_stage import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst,
	input  dec_rec_t i_dec,
	output exe_rec_t o_exe
);

	logic [SHAMT_W-1:0] shamt;
	logic [XLEN-1:0]    alu_res;
	logic [XLEN-1:0]    link_addr;
	logic               lt_s, lt_u;
	exe_rec_t           exe_d;

	assign shamt     = i_dec.op_b[SHAMT_W-1:0];
	assign link_addr = i_dec.pc + XLEN'(4);
	assign lt_s      = $signed(i_dec.op_a) < $signed(i_dec.op_b);
	assign lt_u      = i_dec.op_a < i_dec.op_b;

	// ----------------------------------------
	// ALU
	always_comb begin
		case (i_dec.alu_op)
			ALU_ADD:    alu_res = i_dec.op_a + i_dec.op_b;
			ALU_SUB:    alu_res = i_dec.op_a - i_dec.op_b;
			ALU_SLL:    alu_res = i_dec.op_a << shamt;
			ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, lt_u};
			ALU_XOR:    alu_res = i_dec.op_a ^ i_dec.op_b;
			ALU_SRL:    alu_res = i_dec.op_a >> shamt;
			ALU_SRA:    alu_res = $unsigned($signed(i_dec.op_a) >>> shamt);
			ALU_OR:     alu_res = i_dec.op_a | i_dec.op_b;
			ALU_AND:    alu_res = i_dec.op_a & i_dec.op_b;
			ALU_PASS_B: alu_res = i_dec.op_b;	// lui
			default:    alu_res = '0;
		endcase
	end

	// ----------------------------------------
	// result select
	always_comb begin
		exe_d.valid     = i_dec.valid;
		exe_d.rd_num    = i_dec.rd_num;
		exe_d.writes_rd = i_dec.writes_rd;
		exe_d.illegal   = i_dec.illegal;
		if (i_dec.link) begin
			exe_d.result = link_addr;	// jal, jalr
		end else begin
			exe_d.result = alu_res;
		end
	end

	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		o_exe <= exe_d;
		if (i_rst) begin
			o_exe.valid <= 1'b0;
		end
	end

endmodule

// ==== source/result_stage.sv ====
module result_stage import rv_pipe_pkg::*;
(
	input  exe_rec_t i_exe,
	output wb_rec_t  o_wb,
	output logic     o_illegal
);

	logic rd_nonzero;
	logic legal;

	assign rd_nonzero = (i_exe.rd_num != '0);
	assign legal      = i_exe.valid && !i_exe.illegal;

	// ----------------------------------------
	// writeback record, also feeds the register file
	always_comb begin
		o_wb.valid  = legal && i_exe.writes_rd && rd_nonzero;	// writes to x0 dropped
		o_wb.rd_num = i_exe.rd_num;
		o_wb.value  = i_exe.result;
	end

	// single-cycle pulse per illegal instruction
	assign o_illegal = i_exe.valid && i_exe.illegal;

endmodule

// ==== source/rv_core_top.sv ====
module rv_core_top import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_inst_valid,
	input  logic [ILEN-1:0] i_inst,
	input  logic [XLEN-1:0] i_pc,
	output br_rec_t         o_br,
	output wb_rec_t         o_wb,
	output logic            o_illegal
);

	dec_rec_t dec;
	exe_rec_t exe;
	wb_rec_t  wb;	// loops back to the register file

	// ----------------------------------------
	decode_stage u_decode (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_inst_valid(i_inst_valid),
		.i_inst      (i_inst),
		.i_pc        (i_pc),
		.i_wb        (wb),
		.o_dec       (dec),
		.o_br        (o_br)
	);

	execute_stage u_execute (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_dec(dec),
		.o_exe(exe)
	);

	result_stage u_result (
		.i_exe    (exe),
		.o_wb     (wb),
		.o_illegal(o_illegal)
	);

	assign o_wb = wb;

endmodule

// ==== testbench/core_checker.sv ====
module core_checker import rv_pipe_pkg::*;
(
	input logic     i_clk,
	input logic     i_rst,
	input logic     i_inst_valid,
	input dec_rec_t i_dec,
	input br_rec_t  i_br,
	input wb_rec_t  i_wb
);

	timeunit 1ns;
	timeprecision 100ps;

	// ----------------------------------------
	// a branch report lasts one cycle unless a second one was accepted
	a_br_single: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_br.valid && !i_inst_valid) |=> !i_br.valid)
		else $error("branch report held for two cycles");

	a_rst_clear: assert property (@(posedge i_clk)
		i_rst |=> (!i_dec.valid && !i_br.valid))
		else $error("valid bits not cleared by reset");

	a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_wb.valid && (i_wb.rd_num == '0)))
		else $error("write to x0 marked valid");

endmodule

bind decode_stage core_checker u_checker (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_inst_valid(i_inst_valid),
	.i_dec       (o_dec),
	.i_br        (o_br),
	.i_wb        (i_wb)
);

// ==== testbench/tb_core.sv ====
module tb_core import rv_pipe_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;
		logic        br_exp;
		logic        taken;
		logic [31:0] target;
		logic [4:0]  rd;	// 0 means no write expected
		logic [31:0] val;
		logic        ill;
		logic        b2b;	// next row issued on the following cycle
	} row_t;

	logic        i_clk;
	logic        i_rst;
	logic        i_inst_valid;
	logic [31:0] i_inst;
	logic [31:0] i_pc;
	br_rec_t     o_br;
	wb_rec_t     o_wb;
	logic        o_illegal;

	row_t        rows [$];
	logic [31:0] cur_pc;
	logic [31:0] v1, v2;

	rv_core_top u_dut (.i_clk(i_clk), .i_rst(i_rst), .i_inst_valid(i_inst_valid),
		.i_inst(i_inst), .i_pc(i_pc), .o_br(o_br), .o_wb(o_wb), .o_illegal(o_illegal));

	always #5 i_clk = ~i_clk;

	// ----------------------------------------
	// instruction encoders
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	                                      input logic [4:0] rs1, input logic [2:0] f3,
	                                      input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	                                      input logic [2:0] f3, input logic [4:0] rd,
	                                      input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	                                      input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// ----------------------------------------
	task automatic add_row(input logic [31:0] inst, input logic br_exp, input logic taken,
	                       input logic [31:0] target, input logic [4:0] rd,
	                       input logic [31:0] val, input logic ill, input logic b2b);
		rows.push_back('{inst, cur_pc, br_exp, taken, target, rd, val, ill, b2b});
		cur_pc = cur_pc + 32'd4;
	endtask

	task automatic add_br(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
	                      input logic taken, input logic [12:0] off);
		add_row(enc_b(off, rs2, rs1, f3), 1'b1, taken, cur_pc + {{19{off[12]}}, off},
			5'd0, 32'h0, 1'b0, 1'b0);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic check_br(input row_t r);
		check_value("o_br.valid", o_br.valid, r.br_exp);
		if (r.br_exp) begin
			check_value("o_br.taken", o_br.taken, r.taken);
			check_value("o_br.target", o_br.target, r.target);
		end
	endtask

	task automatic check_result(input row_t r);
		check_value("o_wb.valid", o_wb.valid, r.rd != 5'd0);
		check_value("o_illegal", o_illegal, r.ill);
		if (r.rd != 5'd0) begin
			check_value("o_wb.rd_num", o_wb.rd_num, r.rd);
			check_value("o_wb.value", o_wb.value, r.val);
		end
	endtask

	task automatic wait_result(input int idx);
		int n;
		n = 0;
		while (!(o_wb.valid || o_illegal)) begin
			@(negedge i_clk);
			n++;
			if (n > 10) begin
				$display("timeout waiting for a writeback or illegal flag, row %0d", idx);
				$display("CHECKS FAILED");
				$fatal(1, "timeout");
			end
		end
	endtask

	task automatic drive(input row_t r);
		i_inst_valid = 1'b1;
		i_inst       = r.inst;
		i_pc         = r.pc;
	endtask

	task automatic idle();
		i_inst_valid = 1'b0;
		i_inst       = 32'h0;
	endtask

	// ----------------------------------------
	initial begin
		void'($urandom(32'h74df));
		i_clk = 1'b0;
		i_rst = 1'b1;
		idle();
		i_pc   = 32'h0;
		cur_pc = 32'h100;
		v1 = $urandom() & 32'h7fff_ffff;	// positive
		v2 = $urandom() | 32'h8000_0000;	// negative

		// constants, x1 = v1 and x2 = v2
		add_row({v1[31:12] + v1[11], 5'd1, 7'b0110111}, 0, 0, 0, 5'd1,
			{v1[31:12] + v1[11], 12'h0}, 0, 0);
		add_row(enc_i(v1[11:0], 5'd1, 3'd0, 5'd1, 7'b0010011), 0, 0, 0, 5'd1, v1, 0, 0);
		add_row({v2[31:12] + v2[11], 5'd2, 7'b0110111}, 0, 0, 0, 5'd2,
			{v2[31:12] + v2[11], 12'h0}, 0, 0);
		add_row(enc_i(v2[11:0], 5'd2, 3'd0, 5'd2, 7'b0010011), 0, 0, 0, 5'd2, v2, 0, 0);
		// register forms
		add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 0, 0, 0, 5'd3, v1 + v2, 0, 0);
		add_row(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 0, 0, 0, 5'd4, v1 - v2, 0, 0);
		add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd5), 0, 0, 0, 5'd5, v1 << v2[4:0], 0, 0);
		add_row(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd6), 0, 0, 0, 5'd6, 32'd1, 0, 0);
		add_row(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd7), 0, 0, 0, 5'd7, 32'd0, 0, 0);
		add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd8), 0, 0, 0, 5'd8, v1 ^ v2, 0, 0);
		add_row(enc_r(7'h00, 5'd1, 5'd2, 3'd5, 5'd9), 0, 0, 0, 5'd9, v2 >> v1[4:0], 0, 0);
		add_row(enc_r(7'h20, 5'd1, 5'd2, 3'd5, 5'd10), 0, 0, 0, 5'd10,
			~(~v2 >> v1[4:0]), 0, 0);	// v2 negative, ones shift in
		add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd11), 0, 0, 0, 5'd11, v1 | v2, 0, 0);
		add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd12), 0, 0, 0, 5'd12, v1 & v2, 0, 0);
		// immediate forms
		add_row(enc_i(12'hffb, 5'd2, 3'd2, 5'd13, 7'b0010011), 0, 0, 0, 5'd13,
			{31'h0, $signed(v2) < -5}, 0, 0);
		add_row(enc_i(12'h7ff, 5'd1, 3'd3, 5'd14, 7'b0010011), 0, 0, 0, 5'd14,
			{31'h0, v1 < 32'h7ff}, 0, 0);
		add_row(enc_i(12'hfff, 5'd1, 3'd4, 5'd15, 7'b0010011), 0, 0, 0, 5'd15, ~v1, 0, 0);
		add_row(enc_i(12'h007, 5'd2, 3'd1, 5'd16, 7'b0010011), 0, 0, 0, 5'd16, v2 << 7, 0, 0);
		add_row(enc_i(12'h404, 5'd2, 3'd5, 5'd17, 7'b0010011), 0, 0, 0, 5'd17,
			~(~v2 >> 4), 0, 0);
		// upper immediate and jumps
		add_row({20'h12345, 5'd18, 7'b0010111}, 0, 0, 0, 5'd18, cur_pc + 32'h1234_5000, 0, 0);
		add_row(enc_j(21'h40, 5'd19), 1, 1, cur_pc + 32'h40, 5'd19, cur_pc + 4, 0, 0);
		add_row(enc_i(12'h007, 5'd1, 3'd0, 5'd20, 7'b1100111), 1, 1, (v1 + 7) & ~32'h1,
			5'd20, cur_pc + 4, 0, 0);
		// conditional branches, v1 positive and v2 negative
		add_br(3'd0, 5'd1, 5'd1, 1, 13'h010);
		add_br(3'd0, 5'd1, 5'd2, 0, 13'h1ff0);
		add_br(3'd1, 5'd1, 5'd2, 1, 13'h020);
		add_br(3'd1, 5'd1, 5'd1, 0, 13'h020);
		add_br(3'd4, 5'd2, 5'd1, 1, 13'h1ff0);
		add_br(3'd4, 5'd1, 5'd2, 0, 13'h008);
		add_br(3'd5, 5'd1, 5'd2, 1, 13'h00c);
		add_br(3'd5, 5'd2, 5'd1, 0, 13'h00c);
		add_br(3'd6, 5'd1, 5'd2, 1, 13'h1f00);
		add_br(3'd6, 5'd2, 5'd1, 0, 13'h100);
		add_br(3'd7, 5'd2, 5'd1, 1, 13'h044);
		add_br(3'd7, 5'd1, 5'd2, 0, 13'h044);
		// x0, illegal load, back-to-back pair
		add_row(enc_i(12'h005, 5'd1, 3'd0, 5'd0, 7'b0010011), 0, 0, 0, 5'd0, 0, 0, 0);
		add_row(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd21), 0, 0, 0, 5'd21, v1, 0, 0);
		add_row(enc_i(12'h000, 5'd1, 3'd2, 5'd22, 7'b0000011), 0, 0, 0, 5'd0, 0, 1, 0);
		add_row(enc_i(12'h07b, 5'd0, 3'd0, 5'd23, 7'b0010011), 0, 0, 0, 5'd23, 32'd123, 0, 1);
		add_row(enc_i(12'hfff, 5'd1, 3'd0, 5'd24, 7'b0010011), 0, 0, 0, 5'd24, v1 - 1, 0, 0);

		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		@(negedge i_clk);

		for (int i = 0; i < rows.size(); i++) begin
			drive(rows[i]);
			@(negedge i_clk);
			check_br(rows[i]);
			if (rows[i].b2b) begin
				drive(rows[i+1]);
				@(negedge i_clk);
				idle();
				check_br(rows[i+1]);
				wait_result(i);
				check_result(rows[i]);
				@(negedge i_clk);
				check_result(rows[i+1]);	// one cycle after the first
				i++;
			end else begin
				idle();
				if (rows[i].rd != 5'd0 || rows[i].ill) begin
					wait_result(i);
				end else begin
					@(negedge i_clk);
				end
				check_result(rows[i]);
			end
			repeat ($urandom_range(2, 4)) @(negedge i_clk);
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== filelist.f ====
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/register_file.sv
source/branch_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/rv_core_top.sv
testbench/core_checker.sv
testbench/tb_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - source/rv_isa_pkg.sv
  - source/rv_pipe_pkg.sv
  - source/register_file.sv
  - source/branch_unit.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/result_stage.sv
  - source/rv_core_top.sv
  - target: simulation
    files:
      - testbench/core_checker.sv
      - testbench/tb_core.sv
